/* Makefile */
SIM_DIR := obj_dir
LOG     := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module rv_pipeline_tb \
		-f rv_pipeline.f --Mdir $(SIM_DIR) -o rv_pipeline_sim

run: build
	./$(SIM_DIR)/rv_pipeline_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	verilator --lint-only -Wall --top-module rv_pipeline_top +incdir+source \
		source/rv_pkg.sv source/rv_regfile.sv source/rv_decoder.sv \
		source/rv_execute.sv source/rv_pipeline_top.sv

clean:
	rm -rf $(SIM_DIR) $(LOG)

/* rv_pipeline.f */
+incdir+source
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_decoder.sv
source/rv_execute.sv
source/rv_pipeline_top.sv
tb/rv_pipeline_tb.sv

/* source/rv_decoder.sv */
// Decode and register-read stage
// Captures the incoming instruction strobe, decodes ADDI, ADD and SUB into
// a control word, drives the register-file read ports and assembles the
// payload for the execute stage. Unsupported encodings pass on as
// non-writing entries with the illegal flag set.

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_decoder
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    output ex_payload_t         id_ex
);

    logic        valid_q;
    logic [31:0] instr_q;

    opcode_t     opcode;
    funct3_t     funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    ctrl_t       ctrl;
    logic [`RV_XLEN-1:0] imm;

    // Instruction register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
            instr_q <= '0;
        end else begin
            valid_q <= instr_valid;
            instr_q <= instr;
        end
    end

    // Field split
    assign opcode   = opcode_t'(instr_q[6:0]);
    assign rd       = instr_q[11:7];
    assign funct3   = instr_q[14:12];
    assign rs1_addr = instr_q[19:15];
    assign rs2_addr = instr_q[24:20];
    assign funct7   = instr_q[31:25];

    // I-type immediate
    assign imm = {{(`RV_XLEN-12){instr_q[31]}}, instr_q[31:20]};

    always_comb begin
        ctrl = CTRL_NOP; // Bubble
        if (valid_q) begin
            unique case (opcode)
                OP_IMM: begin
                    unique case (funct3)
                        ADDI:    ctrl = CTRL_ADDI;
                        default: ctrl = CTRL_INVALID;
                    endcase
                end
                OP: begin
                    unique case (funct3)
                        ADD_SUB: ctrl = funct7[5] ? CTRL_SUB : CTRL_ADD;
                        default: ctrl = CTRL_INVALID;
                    endcase
                end
                default: ctrl = CTRL_INVALID;
            endcase
        end
    end

    always_comb begin
        id_ex.valid    = valid_q;
        id_ex.ctrl     = ctrl;
        id_ex.rd       = rd;
        id_ex.rs1_data = rs1_data; // Same-cycle regfile read
        id_ex.rs2_data = rs2_data;
        id_ex.imm      = imm;
    end

endmodule

/* source/rv_defines.svh */
// Global sizes for the three-stage integer pipeline
// Included by the package and by every module that needs the data width
// or the register count

`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path width in bits
`define RV_XLEN  32

// Architectural registers, x0 included
`define RV_NREGS 32

`endif

/* source/rv_execute.sv */
// Execute stage
// Registers the decode payload, picks the second operand from the register
// or the immediate, adds or subtracts with 32-bit wraparound and registers
// the result together with its writeback control.

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  ex_payload_t id_ex,
    output wb_payload_t ex_wb
);

    ex_payload_t         ex_q;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [`RV_XLEN-1:0] result;

    // Execute stage register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_q.valid <= 1'b0;
            ex_q.ctrl  <= CTRL_NOP;
        end else begin
            ex_q <= id_ex;
        end
    end

    assign op1 = ex_q.rs1_data;
    assign op2 = (ex_q.ctrl.op2_sel == OP2_IMM) ? ex_q.imm : ex_q.rs2_data;

    always_comb begin
        unique case (ex_q.ctrl.alu_op)
            ALU_SUB: result = op1 - op2; // Wraps mod 2^32
            default: result = op1 + op2;
        endcase
    end

    // Writeback register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_wb.valid   <= 1'b0;
            ex_wb.illegal <= 1'b0;
            ex_wb.write   <= 1'b0;
        end else begin
            ex_wb.valid   <= ex_q.valid;
            ex_wb.illegal <= ex_q.ctrl.illegal;
            ex_wb.write   <= ex_q.ctrl.write;
        end
    end

    always_ff @(posedge clk) begin
        ex_wb.rd     <= ex_q.rd;
        ex_wb.result <= result;
    end

endmodule

/* source/rv_pipeline_top.sv */
// Top level of the three-stage integer pipeline
// Instructions enter as a plain strobe and pass through decode, execute and
// writeback. Each result is written to the register file and shown on the
// writeback ports for one cycle. Illegal encodings show up there as well,
// flagged and without a register write.

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_pipeline_top
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    output logic                wb_valid,
    output logic                wb_illegal,
    output logic [4:0]          wb_rd,
    output logic [`RV_XLEN-1:0] wb_data
);

    ex_payload_t         id_ex;
    wb_payload_t         ex_wb;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                wr_en;

    rv_decoder u_decoder (
        .clk         (clk),
        .resetn      (resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .id_ex       (id_ex)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .resetn   (resetn),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_en    (wr_en),
        .wr_addr  (ex_wb.rd),
        .wr_data  (ex_wb.result),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute u_execute (
        .clk    (clk),
        .resetn (resetn),
        .id_ex  (id_ex),
        .ex_wb  (ex_wb)
    );

    assign wr_en = ex_wb.valid && ex_wb.write; // x0 filtered in regfile

    assign wb_valid   = ex_wb.valid;
    assign wb_illegal = ex_wb.illegal;
    assign wb_rd      = ex_wb.rd;
    assign wb_data    = ex_wb.result;

endmodule

/* source/rv_pkg.sv */
// Shared types for the three-stage integer pipeline
// Holds the opcode and ALU encodings, the decoded control word and the
// payloads passed from decode to execute and from execute to writeback.
// Modules take it with a wildcard import in their header.

`include "rv_defines.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011, // I-type arithmetic
        OP     = 7'b0110011  // R-type arithmetic
    } opcode_t;

    // ADDI and ADD/SUB both use funct3 000, each inside its own opcode group
    typedef logic [2:0] funct3_t;

    localparam funct3_t ADDI    = 3'b000;
    localparam funct3_t ADD_SUB = 3'b000;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_t;

    typedef enum logic {
        OP2_RS2 = 1'b0, // Second register operand
        OP2_IMM = 1'b1  // Sign-extended immediate
    } op2_sel_t;

    typedef struct packed {
        logic     write;
        logic     illegal;
        alu_t     alu_op;
        op2_sel_t op2_sel;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP     = '{1'b0, 1'b0, ALU_ADD, OP2_RS2};
    localparam ctrl_t CTRL_ADDI    = '{1'b1, 1'b0, ALU_ADD, OP2_IMM};
    localparam ctrl_t CTRL_ADD     = '{1'b1, 1'b0, ALU_ADD, OP2_RS2};
    localparam ctrl_t CTRL_SUB     = '{1'b1, 1'b0, ALU_SUB, OP2_RS2};
    localparam ctrl_t CTRL_INVALID = '{1'b0, 1'b1, ALU_ADD, OP2_RS2};

    // Decode to execute
    typedef struct packed {
        logic                valid;
        ctrl_t               ctrl;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [`RV_XLEN-1:0] imm;
    } ex_payload_t;

    // Execute to writeback
    typedef struct packed {
        logic                valid;
        logic                illegal;
        logic                write;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] result;
    } wb_payload_t;

endpackage

/* source/rv_regfile.sv */
// Integer register file
// 32 entries with two combinational read ports and one synchronous write
// port. x0 always reads as zero and ignores writes. A read that hits the
// register being written in the same cycle returns the new data, so a
// consumer two slots behind its producer needs no forwarding.

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    input  logic                wr_en,
    input  logic [4:0]          wr_addr,
    input  logic [`RV_XLEN-1:0] wr_data,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wr_live;

    assign wr_live = wr_en && (wr_addr != 5'd0); // x0 is read-only

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        if (rs1_addr == 5'd0)
            rs1_data = '0;
        else if (wr_live && (wr_addr == rs1_addr))
            rs1_data = wr_data; // Write-through
        else
            rs1_data = regs[rs1_addr];
    end

    always_comb begin
        if (rs2_addr == 5'd0)
            rs2_data = '0;
        else if (wr_live && (wr_addr == rs2_addr))
            rs2_data = wr_data; // Write-through
        else
            rs2_data = regs[rs2_addr];
    end

endmodule

/* tb/rv_pipeline_tb.sv */
// Testbench for the three-stage integer pipeline
// Builds a table of ADDI, ADD, SUB, illegal and bubble rows, drives one row
// per cycle and checks each writeback against a reference register model.
// A result is due three cycles after its row is sampled; any writeback at
// another time, or a missing one, counts as an error.

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_pipeline_tb;

    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 20;

    typedef struct packed {
        logic [31:0]         due;
        logic                illegal;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } expect_t;

    logic                clk = 1'b0;
    logic                resetn;
    logic                instr_valid;
    logic [31:0]         instr;
    logic                wb_valid;
    logic                wb_illegal;
    logic [4:0]          wb_rd;
    logic [`RV_XLEN-1:0] wb_data;

    // Stimulus table
    logic        row_valid [$];
    logic [31:0] row_instr [$];
    string       row_name  [$];

    expect_t             exp_q  [$];
    string               name_q [$];
    logic [`RV_XLEN-1:0] ref_regs [`RV_NREGS];

    logic [31:0] cycle = '0;
    logic [31:0] cycle_limit = 32'hffff_ffff;
    int          checks = 0;
    int          errors = 0;

    rv_pipeline_top dut (
        .clk         (clk),
        .resetn      (resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_illegal  (wb_illegal),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_rtype(input logic [6:0] funct7,
                                              input logic [2:0] funct3,
                                              input logic [4:0] rd,
                                              input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [11:0] rand_imm();
        logic [31:0] r;
        r = $urandom();
        return r[11:0];
    endfunction

    task automatic add_row(input logic valid, input logic [31:0] word, input string name);
        row_valid.push_back(valid);
        row_instr.push_back(word);
        row_name.push_back(name);
    endtask

    task automatic build_table();
        repeat (3) add_row(1'b0, 32'h0, "idle after reset");
        add_row(1'b1, enc_addi(5'd1, 5'd0, 12'd100), "addi x1 100");
        add_row(1'b1, enc_addi(5'd2, 5'd0, 12'hffb), "addi x2 -5");
        add_row(1'b1, enc_addi(5'd3, 5'd0, rand_imm()), "addi x3 random");
        add_row(1'b1, enc_addi(5'd4, 5'd0, 12'h7ff), "addi x4 max");
        add_row(1'b1, enc_addi(5'd5, 5'd0, 12'h800), "addi x5 min");
        add_row(1'b1, enc_addi(5'd6, 5'd0, rand_imm()), "addi x6 random");
        add_row(1'b0, 32'h0, "bubble");
        add_row(1'b1, enc_rtype(7'h00, 3'b000, 5'd7, 5'd1, 5'd2), "add x7 x1 x2");
        add_row(1'b1, enc_rtype(7'h00, 3'b000, 5'd8, 5'd2, 5'd5), "add x8 x2 x5");
        add_row(1'b1, enc_rtype(7'h20, 3'b000, 5'd9, 5'd0, 5'd1), "sub x9 x0 x1");
        add_row(1'b1, enc_rtype(7'h20, 3'b000, 5'd10, 5'd5, 5'd4), "sub x10 x5 x4");
        add_row(1'b1, enc_rtype(7'h00, 3'b000, 5'd11, 5'd3, 5'd6), "add x11 x3 x6");
        // Consumer two slots behind its producer
        add_row(1'b1, enc_rtype(7'h00, 3'b000, 5'd13, 5'd1, 5'd4), "add x13 x1 x4");
        add_row(1'b1, enc_addi(5'd14, 5'd2, 12'd3), "addi x14 x2 3");
        add_row(1'b1, enc_rtype(7'h20, 3'b000, 5'd15, 5'd13, 5'd1), "sub x15 x13 x1");
        add_row(1'b0, 32'h0, "bubble");
        add_row(1'b1, enc_addi(5'd16, 5'd15, rand_imm()), "addi x16 x15 random");
        add_row(1'b1, enc_addi(5'd0, 5'd0, 12'd55), "addi x0 55");
        add_row(1'b0, 32'h0, "bubble");
        add_row(1'b1, enc_rtype(7'h00, 3'b000, 5'd17, 5'd0, 5'd1), "add x17 x0 x1");
        add_row(1'b1, enc_addi(5'd18, 5'd0, 12'd0), "addi x18 x0 0");
        add_row(1'b1, {12'h004, 5'd0, 3'b010, 5'd1, 7'b0000011}, "illegal opcode x1");
        add_row(1'b1, {7'h00, 5'd3, 5'd2, 3'b001, 5'd2, 7'b0010011}, "illegal funct3 x2");
        add_row(1'b1, enc_rtype(7'h00, 3'b111, 5'd3, 5'd3, 5'd3), "illegal funct3 x3");
        add_row(1'b0, 32'h0, "bubble");
        add_row(1'b1, enc_addi(5'd19, 5'd1, 12'd0), "readback x1");
        add_row(1'b1, enc_addi(5'd20, 5'd2, 12'd0), "readback x2");
        add_row(1'b1, enc_rtype(7'h00, 3'b000, 5'd21, 5'd3, 5'd0), "readback x3");
        add_row(1'b1, enc_rtype(7'h20, 3'b000, 5'd22, 5'd9, 5'd10), "sub x22 x9 x10");
        repeat (2) add_row(1'b0, 32'h0, "bubble");
    endtask

    // Reference model for one instruction in program order
    task automatic model_instr(input logic [31:0] word, input string name,
                               input logic [31:0] due);
        logic [6:0]          opcode;
        logic [2:0]          funct3;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] imm;
        expect_t             e;
        opcode    = word[6:0];
        funct3    = word[14:12];
        a         = ref_regs[word[19:15]];
        b         = ref_regs[word[24:20]];
        imm       = `RV_XLEN'($signed(word[31:20]));
        e.due     = due;
        e.rd      = word[11:7];
        e.illegal = 1'b0;
        e.data    = '0;
        if (opcode == 7'b0010011 && funct3 == 3'b000) begin
            e.data = a + imm;
        end else if (opcode == 7'b0110011 && funct3 == 3'b000) begin
            e.data = word[30] ? a - b : a + b; // funct7 bit 5 picks SUB
        end else begin
            e.illegal = 1'b1;
        end
        if (!e.illegal && e.rd != 5'd0) begin
            ref_regs[e.rd] = e.data;
        end
        exp_q.push_back(e);
        name_q.push_back(name);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic end_run(input logic timed_out);
        int missing;
        missing = exp_q.size();
        if (missing != 0) begin
            $display("%0d expected results never reached writeback", missing);
        end
        $display("Checks: %0d, errors: %0d, missing results: %0d", checks, errors, missing);
        if (errors == 0 && missing == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // Monitor and timeout sampled mid-cycle
    always @(negedge clk) begin
        expect_t e;
        string   name;
        if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles, the pipeline did not drain", cycle);
            end_run(1'b1);
        end else if (resetn) begin
            if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                if (!wb_valid) begin
                    errors++;
                    $display("No writeback at cycle %0d for %s", cycle, name);
                end else begin
                    compare_value({name, " illegal"}, 32'(e.illegal), 32'(wb_illegal));
                    compare_value({name, " rd"}, 32'(e.rd), 32'(wb_rd));
                    if (!e.illegal) begin
                        compare_value({name, " data"}, e.data, wb_data);
                    end
                end
            end else if (wb_valid) begin
                errors++;
                $display("Writeback at cycle %0d with no instruction due", cycle);
            end
        end
    end

    initial begin
        resetn      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int r = 0; r < `RV_NREGS; r++) begin
            ref_regs[r] = '0;
        end
        void'($urandom(32'haffa_8910));
        build_table();
        cycle_limit = row_valid.size() + RESET_CYCLES + DRAIN_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        for (int i = 0; i < row_valid.size(); i++) begin
            @(posedge clk);
            instr_valid <= row_valid[i];
            instr       <= row_instr[i];
            if (row_valid[i]) begin
                model_instr(row_instr[i], row_name[i], cycle + 32'd4); // Sampled next edge
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= '0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk); // Catch stray writebacks
        end_run(1'b0);
    end

endmodule
